//--- hdl/ext_mem_defs.svh
`ifndef EXT_MEM_DEFS_SVH
`define EXT_MEM_DEFS_SVH

// Byte address width of both front ends and the memory port
`define EXT_MEM_ADDR_W 16

// One bus word
`define EXT_MEM_DATA_W 32

// Cache geometry, direct mapped
`define EXT_MEM_LINE_WORDS 4
`define EXT_MEM_LINES 16

// Hit and miss counter width
`define EXT_MEM_CNT_W 16

`endif

//--- hdl/mem_bus_pkg.sv
`include "ext_mem_defs.svh"

package mem_bus_pkg;

   typedef logic [`EXT_MEM_ADDR_W-1:0]   addr_t;
   typedef logic [`EXT_MEM_DATA_W-1:0]   data_t;
   typedef logic [`EXT_MEM_DATA_W/8-1:0] strb_t;  // One enable per byte lane

   // Native bus request, held by the master until ready
   typedef struct packed {
      logic  valid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;  // All zero for a read
   } mem_req_t;

   // Native bus response, ready is a single cycle pulse
   typedef struct packed {
      data_t rdata;
      logic  ready;
   } mem_resp_t;

endpackage

//--- hdl/cache_pkg.sv
`include "ext_mem_defs.svh"

package cache_pkg;

   // Address fields below the tag
   typedef logic [$clog2(`EXT_MEM_LINES)-1:0]      index_t;
   typedef logic [$clog2(`EXT_MEM_LINE_WORDS)-1:0] word_off_t;

   // Whatever is left above index, word offset and byte lane
   typedef logic [`EXT_MEM_ADDR_W - $clog2(`EXT_MEM_LINES)
                  - $clog2(`EXT_MEM_LINE_WORDS)
                  - $clog2(`EXT_MEM_DATA_W/8) - 1:0] tag_t;

   typedef logic [`EXT_MEM_CNT_W-1:0] cnt_t;

   // Controller FSM
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,  // Tag compare on the registered array read
      REFILL,  // Fetch line word by word
      WRITE,   // Write-through on the back end
      DONE     // Front-end ready
   } cache_state_e;

endpackage

//--- hdl/cache_store.sv
`include "ext_mem_defs.svh"

module cache_store (
   input  logic                                         clk,
   input  logic                                         rst_n,
   // Registered read port
   input  cache_pkg::index_t                            rd_index,
   output cache_pkg::tag_t                              rd_tag,
   output logic                                         rd_valid,
   output mem_bus_pkg::data_t [`EXT_MEM_LINE_WORDS-1:0] rd_line,
   // Whole line fill after a refill
   input  logic                                         fill_en,
   input  cache_pkg::index_t                            fill_index,
   input  cache_pkg::tag_t                              fill_tag,
   input  mem_bus_pkg::data_t [`EXT_MEM_LINE_WORDS-1:0] fill_line,
   // Strobed word write on a write hit
   input  logic                                         wr_en,
   input  cache_pkg::index_t                            wr_index,
   input  cache_pkg::word_off_t                         wr_off,
   input  mem_bus_pkg::data_t                           wr_data,
   input  mem_bus_pkg::strb_t                           wr_strb
);

   localparam int LINES = `EXT_MEM_LINES;
   localparam int LANES = $bits(mem_bus_pkg::strb_t);

   cache_pkg::tag_t                              tag_mem  [LINES];
   mem_bus_pkg::data_t [`EXT_MEM_LINE_WORDS-1:0] data_mem [LINES];
   logic [LINES-1:0]                             valid_q;

   // Valid bit per line
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q  <= '0;
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= valid_q[rd_index];
         if (fill_en) begin
            valid_q[fill_index] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      rd_tag  <= tag_mem[rd_index];   // Old contents on a same cycle write
      rd_line <= data_mem[rd_index];

      if (fill_en) begin
         tag_mem[fill_index]  <= fill_tag;
         data_mem[fill_index] <= fill_line;
      end

      // Only enabled byte lanes change
      if (wr_en) begin
         for (int b = 0; b < LANES; b++) begin
            if (wr_strb[b]) begin
               data_mem[wr_index][wr_off][8*b +: 8] <= wr_data[8*b +: 8];
            end
         end
      end
   end

endmodule

//--- hdl/cache_ctrl.sv
`include "ext_mem_defs.svh"

module cache_ctrl (
   input  logic                                         clk,
   input  logic                                         rst_n,
   // Front end
   input  mem_bus_pkg::mem_req_t                        fe_req,
   output mem_bus_pkg::mem_resp_t                       fe_resp,
   // Back end, one word per transfer
   output mem_bus_pkg::mem_req_t                        be_req,
   input  mem_bus_pkg::mem_resp_t                       be_resp,
   // Store side
   output cache_pkg::index_t                            rd_index,
   input  cache_pkg::tag_t                              rd_tag,
   input  logic                                         rd_valid,
   input  mem_bus_pkg::data_t [`EXT_MEM_LINE_WORDS-1:0] rd_line,
   output logic                                         fill_en,
   output cache_pkg::index_t                            fill_index,
   output cache_pkg::tag_t                              fill_tag,
   output mem_bus_pkg::data_t [`EXT_MEM_LINE_WORDS-1:0] fill_line,
   output logic                                         wr_en,
   output cache_pkg::index_t                            wr_index,
   output cache_pkg::word_off_t                         wr_off,
   output mem_bus_pkg::data_t                           wr_data,
   output mem_bus_pkg::strb_t                           wr_strb,
   // Statistics
   output cache_pkg::cnt_t                              hit_cnt,
   output cache_pkg::cnt_t                              miss_cnt
);

   localparam int OFF_LSB = $clog2(`EXT_MEM_DATA_W / 8);
   localparam int IDX_LSB = OFF_LSB + $bits(cache_pkg::word_off_t);
   localparam int TAG_LSB = IDX_LSB + $bits(cache_pkg::index_t);
   localparam cache_pkg::word_off_t LAST_OFF =
      cache_pkg::word_off_t'(`EXT_MEM_LINE_WORDS - 1);

   cache_pkg::cache_state_e                      state_q;
   cache_pkg::cache_state_e                      state_d;
   mem_bus_pkg::mem_req_t                        req_q;     // Latched front-end request
   cache_pkg::word_off_t                         off_q;     // Refill word counter
   mem_bus_pkg::data_t [`EXT_MEM_LINE_WORDS-1:0] line_q;    // Words gathered so far
   mem_bus_pkg::data_t [`EXT_MEM_LINE_WORDS-1:0] line_nxt;
   mem_bus_pkg::data_t                           rdata_q;
   logic                                         wr_hit_q;  // Write found its line
   cache_pkg::tag_t                              req_tag;
   cache_pkg::index_t                            req_index;
   cache_pkg::word_off_t                         req_off;
   logic                                         req_write;
   logic                                         hit;

   assign req_tag   = req_q.addr[TAG_LSB +: $bits(cache_pkg::tag_t)];
   assign req_index = req_q.addr[IDX_LSB +: $bits(cache_pkg::index_t)];
   assign req_off   = req_q.addr[OFF_LSB +: $bits(cache_pkg::word_off_t)];
   assign req_write = |req_q.wstrb;

   // Start the array read as soon as the request shows up
   assign rd_index = (state_q == cache_pkg::IDLE) ?
                     fe_req.addr[IDX_LSB +: $bits(cache_pkg::index_t)] : req_index;

   assign hit = rd_valid && (rd_tag == req_tag);

   // Current refill word dropped into place
   always_comb begin
      line_nxt          = line_q;
      line_nxt[off_q]   = be_resp.rdata;
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         cache_pkg::IDLE: begin
            if (fe_req.valid) state_d = cache_pkg::LOOKUP;
         end
         cache_pkg::LOOKUP: begin
            if (req_write)  state_d = cache_pkg::WRITE;
            else if (hit)   state_d = cache_pkg::DONE;
            else            state_d = cache_pkg::REFILL;
         end
         cache_pkg::REFILL: begin
            if (be_resp.ready && off_q == LAST_OFF) state_d = cache_pkg::DONE;
         end
         cache_pkg::WRITE: begin
            if (be_resp.ready) state_d = cache_pkg::DONE;
         end
         default: state_d = cache_pkg::IDLE;  // DONE lasts one cycle
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q  <= cache_pkg::IDLE;
         off_q    <= '0;
         wr_hit_q <= 1'b0;
         hit_cnt  <= '0;
         miss_cnt <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == cache_pkg::LOOKUP) begin
            wr_hit_q <= hit;
            off_q    <= '0;
            // Writes count as neither
            if (!req_write && hit)  hit_cnt  <= hit_cnt + 1'b1;
            if (!req_write && !hit) miss_cnt <= miss_cnt + 1'b1;
         end
         if (state_q == cache_pkg::REFILL && be_resp.ready) begin
            off_q <= off_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == cache_pkg::IDLE && fe_req.valid) begin
         req_q <= fe_req;
      end
      if (state_q == cache_pkg::LOOKUP) begin
         rdata_q <= rd_line[req_off];   // Hit data
      end
      if (state_q == cache_pkg::REFILL && be_resp.ready) begin
         line_q  <= line_nxt;
         rdata_q <= line_nxt[req_off];  // Complete on the last word
      end
   end

   always_comb begin
      be_req = '0;
      case (state_q)
         cache_pkg::REFILL: begin
            be_req.valid = 1'b1;
            be_req.addr  = {req_tag, req_index, off_q, {OFF_LSB{1'b0}}};
         end
         cache_pkg::WRITE: begin
            be_req.valid = 1'b1;
            be_req.addr  = req_q.addr;
            be_req.wdata = req_q.wdata;
            be_req.wstrb = req_q.wstrb;
         end
         default: ;
      endcase
   end

   // Line goes in with the last refill word
   assign fill_en    = (state_q == cache_pkg::REFILL) && be_resp.ready && (off_q == LAST_OFF);
   assign fill_index = req_index;
   assign fill_tag   = req_tag;
   assign fill_line  = line_nxt;

   // Cached copy follows memory on the write-through ready
   assign wr_en    = (state_q == cache_pkg::WRITE) && be_resp.ready && wr_hit_q;
   assign wr_index = req_index;
   assign wr_off   = req_off;
   assign wr_data  = req_q.wdata;
   assign wr_strb  = req_q.wstrb;

   assign fe_resp.rdata = rdata_q;
   assign fe_resp.ready = (state_q == cache_pkg::DONE);

endmodule

//--- hdl/bus_merge.sv
module bus_merge (
   input  logic                         clk,
   input  logic                         rst_n,
   // Masters, 0 is the data cache and 1 the instruction cache
   input  mem_bus_pkg::mem_req_t  [1:0] m_req,
   output mem_bus_pkg::mem_resp_t [1:0] m_resp,
   // Shared slave
   output mem_bus_pkg::mem_req_t        s_req,
   input  mem_bus_pkg::mem_resp_t       s_resp
);

   logic busy_q;   // Transfer started, waiting for ready
   logic grant_q;
   logic grant;

   // Data cache wins a tie when idle
   assign grant = busy_q ? grant_q : !m_req[0].valid;

   assign s_req = m_req[grant];

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         m_resp[i].rdata = s_resp.rdata;
         m_resp[i].ready = s_resp.ready && s_req.valid && (grant == 1'(i));
      end
   end

   // Grant held until the slave's ready has been passed back
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy_q  <= 1'b0;
         grant_q <= 1'b0;
      end else if (s_req.valid) begin
         busy_q  <= !s_resp.ready;
         grant_q <= grant;
      end
   end

endmodule

//--- hdl/ext_mem.sv
`include "ext_mem_defs.svh"

module ext_mem (
   input  logic                   clk,
   input  logic                   rst_n,
   // Instruction bus
   input  mem_bus_pkg::mem_req_t  i_req,
   output mem_bus_pkg::mem_resp_t i_resp,
   // Data bus
   input  mem_bus_pkg::mem_req_t  d_req,
   output mem_bus_pkg::mem_resp_t d_resp,
   // External memory, native bus
   output mem_bus_pkg::mem_req_t  mem_req,
   input  mem_bus_pkg::mem_resp_t mem_resp,
   // Statistics
   output cache_pkg::cnt_t        i_hit_cnt,
   output cache_pkg::cnt_t        i_miss_cnt,
   output cache_pkg::cnt_t        d_hit_cnt,
   output cache_pkg::cnt_t        d_miss_cnt
);

   // Back ends, 0 data cache and 1 instruction cache
   mem_bus_pkg::mem_req_t  [1:0] be_req;
   mem_bus_pkg::mem_resp_t [1:0] be_resp;

   // Instruction cache store side
   cache_pkg::index_t                            icache_rd_index;
   cache_pkg::tag_t                              icache_rd_tag;
   logic                                         icache_rd_valid;
   mem_bus_pkg::data_t [`EXT_MEM_LINE_WORDS-1:0] icache_rd_line;
   logic                                         icache_fill_en;
   cache_pkg::index_t                            icache_fill_index;
   cache_pkg::tag_t                              icache_fill_tag;
   mem_bus_pkg::data_t [`EXT_MEM_LINE_WORDS-1:0] icache_fill_line;
   logic                                         icache_wr_en;
   cache_pkg::index_t                            icache_wr_index;
   cache_pkg::word_off_t                         icache_wr_off;
   mem_bus_pkg::data_t                           icache_wr_data;
   mem_bus_pkg::strb_t                           icache_wr_strb;

   // Data cache store side
   cache_pkg::index_t                            dcache_rd_index;
   cache_pkg::tag_t                              dcache_rd_tag;
   logic                                         dcache_rd_valid;
   mem_bus_pkg::data_t [`EXT_MEM_LINE_WORDS-1:0] dcache_rd_line;
   logic                                         dcache_fill_en;
   cache_pkg::index_t                            dcache_fill_index;
   cache_pkg::tag_t                              dcache_fill_tag;
   mem_bus_pkg::data_t [`EXT_MEM_LINE_WORDS-1:0] dcache_fill_line;
   logic                                         dcache_wr_en;
   cache_pkg::index_t                            dcache_wr_index;
   cache_pkg::word_off_t                         dcache_wr_off;
   mem_bus_pkg::data_t                           dcache_wr_data;
   mem_bus_pkg::strb_t                           dcache_wr_strb;

   cache_ctrl icache_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .fe_req     (i_req),
      .fe_resp    (i_resp),
      .be_req     (be_req[1]),
      .be_resp    (be_resp[1]),
      .rd_index   (icache_rd_index),
      .rd_tag     (icache_rd_tag),
      .rd_valid   (icache_rd_valid),
      .rd_line    (icache_rd_line),
      .fill_en    (icache_fill_en),
      .fill_index (icache_fill_index),
      .fill_tag   (icache_fill_tag),
      .fill_line  (icache_fill_line),
      .wr_en      (icache_wr_en),
      .wr_index   (icache_wr_index),
      .wr_off     (icache_wr_off),
      .wr_data    (icache_wr_data),
      .wr_strb    (icache_wr_strb),
      .hit_cnt    (i_hit_cnt),
      .miss_cnt   (i_miss_cnt)
   );

   cache_store icache_store (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd_index   (icache_rd_index),
      .rd_tag     (icache_rd_tag),
      .rd_valid   (icache_rd_valid),
      .rd_line    (icache_rd_line),
      .fill_en    (icache_fill_en),
      .fill_index (icache_fill_index),
      .fill_tag   (icache_fill_tag),
      .fill_line  (icache_fill_line),
      .wr_en      (icache_wr_en),
      .wr_index   (icache_wr_index),
      .wr_off     (icache_wr_off),
      .wr_data    (icache_wr_data),
      .wr_strb    (icache_wr_strb)
   );

   cache_ctrl dcache_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .fe_req     (d_req),
      .fe_resp    (d_resp),
      .be_req     (be_req[0]),
      .be_resp    (be_resp[0]),
      .rd_index   (dcache_rd_index),
      .rd_tag     (dcache_rd_tag),
      .rd_valid   (dcache_rd_valid),
      .rd_line    (dcache_rd_line),
      .fill_en    (dcache_fill_en),
      .fill_index (dcache_fill_index),
      .fill_tag   (dcache_fill_tag),
      .fill_line  (dcache_fill_line),
      .wr_en      (dcache_wr_en),
      .wr_index   (dcache_wr_index),
      .wr_off     (dcache_wr_off),
      .wr_data    (dcache_wr_data),
      .wr_strb    (dcache_wr_strb),
      .hit_cnt    (d_hit_cnt),
      .miss_cnt   (d_miss_cnt)
   );

   cache_store dcache_store (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd_index   (dcache_rd_index),
      .rd_tag     (dcache_rd_tag),
      .rd_valid   (dcache_rd_valid),
      .rd_line    (dcache_rd_line),
      .fill_en    (dcache_fill_en),
      .fill_index (dcache_fill_index),
      .fill_tag   (dcache_fill_tag),
      .fill_line  (dcache_fill_line),
      .wr_en      (dcache_wr_en),
      .wr_index   (dcache_wr_index),
      .wr_off     (dcache_wr_off),
      .wr_data    (dcache_wr_data),
      .wr_strb    (dcache_wr_strb)
   );

   // One memory port for both caches
   bus_merge u_bus_merge (
      .clk    (clk),
      .rst_n  (rst_n),
      .m_req  (be_req),
      .m_resp (be_resp),
      .s_req  (mem_req),
      .s_resp (mem_resp)
   );

endmodule

//--- test/tb_mem_model.sv
module tb_mem_model (
   input  logic                   clk,
   input  logic                   rst_n,
   input  mem_bus_pkg::mem_req_t  req,
   output mem_bus_pkg::mem_resp_t resp
);

   localparam int          WORDS     = 4096;
   localparam logic [31:0] SEED      = 32'h8cb1ac67;
   localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1

   mem_bus_pkg::data_t mem [WORDS];
   logic [31:0]        lfsr_q;
   logic               busy_q;   // Request seen and wait count running
   logic [1:0]         wait_q;
   logic [11:0]        word;

   assign word = req.addr[13:2];

   // Right shifting Galois form
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      lfsr_next = {1'b0, state[31:1]} ^ (state[0] ? LFSR_TAPS : 32'h0);
   endfunction

   // Bus idle before the first clock edge
   initial resp = '0;

   always @(posedge clk) begin : serve
      logic [1:0] draw;
      if (!rst_n) begin
         lfsr_q = SEED;
         busy_q <= 1'b0;
         wait_q <= '0;
         resp   <= '0;
         for (int i = 0; i < WORDS; i++) begin
            mem[i] <= 32'(i) ^ 32'h5a5a0000;
         end
      end else begin
         resp.ready <= 1'b0;   // Single cycle pulse
         if (!resp.ready && req.valid) begin
            if (!busy_q) begin
               // One LFSR step per latency bit
               draw[0] = lfsr_q[0];
               lfsr_q  = lfsr_next(lfsr_q);
               draw[1] = lfsr_q[0];
               lfsr_q  = lfsr_next(lfsr_q);
               wait_q <= draw;
               busy_q <= 1'b1;
            end else if (wait_q == 2'd0) begin
               busy_q     <= 1'b0;
               resp.ready <= 1'b1;
               resp.rdata <= mem[word];
               for (int b = 0; b < 4; b++) begin
                  if (req.wstrb[b]) mem[word][8*b +: 8] <= req.wdata[8*b +: 8];
               end
            end else begin
               wait_q <= wait_q - 1'b1;
            end
         end
      end
   end

endmodule

//--- test/tb_ext_mem.sv
`include "ext_mem_defs.svh"

module tb_ext_mem;

   localparam int   NUM_ROWS       = 19;
   localparam int   TIMEOUT_CYCLES = NUM_ROWS * 40;
   localparam logic BUS_I = 1'b0;
   localparam logic BUS_D = 1'b1;
   localparam logic OP_RD = 1'b0;
   localparam logic OP_WR = 1'b1;

   typedef struct packed {
      logic                is_data;
      logic                is_write;
      logic                pair;     // Starts together with the next row
      logic                calc;     // Expected data from the memory model
      mem_bus_pkg::addr_t  addr;
      mem_bus_pkg::data_t  wdata;
      mem_bus_pkg::strb_t  wstrb;
      mem_bus_pkg::data_t  exp;
   } row_t;

   logic                   clk;
   logic                   rst_n;
   mem_bus_pkg::mem_req_t  i_req;
   mem_bus_pkg::mem_resp_t i_resp;
   mem_bus_pkg::mem_req_t  d_req;
   mem_bus_pkg::mem_resp_t d_resp;
   mem_bus_pkg::mem_req_t  mem_req;
   mem_bus_pkg::mem_resp_t mem_resp;
   cache_pkg::cnt_t        i_hit_cnt;
   cache_pkg::cnt_t        i_miss_cnt;
   cache_pkg::cnt_t        d_hit_cnt;
   cache_pkg::cnt_t        d_miss_cnt;

   row_t               stim [NUM_ROWS];
   mem_bus_pkg::data_t shadow [4096];                     // Expected memory contents
   logic               tag_valid [2][`EXT_MEM_LINES];     // Index 0 icache, 1 dcache
   cache_pkg::tag_t    tag_ref [2][`EXT_MEM_LINES];
   int                 exp_hit [2];
   int                 exp_miss [2];
   int                 errors;
   int                 checks;

   ext_mem u_ext_mem (
      .clk        (clk),
      .rst_n      (rst_n),
      .i_req      (i_req),
      .i_resp     (i_resp),
      .d_req      (d_req),
      .d_resp     (d_resp),
      .mem_req    (mem_req),
      .mem_resp   (mem_resp),
      .i_hit_cnt  (i_hit_cnt),
      .i_miss_cnt (i_miss_cnt),
      .d_hit_cnt  (d_hit_cnt),
      .d_miss_cnt (d_miss_cnt)
   );

   tb_mem_model u_mem_model (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (mem_req),
      .resp  (mem_resp)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic row_t make_row(input logic is_data, input logic is_write,
                                     input logic pair, input logic calc,
                                     input mem_bus_pkg::addr_t addr,
                                     input mem_bus_pkg::data_t wdata,
                                     input mem_bus_pkg::strb_t wstrb,
                                     input mem_bus_pkg::data_t exp);
      make_row = {is_data, is_write, pair, calc, addr, wdata, wstrb, exp};
   endfunction

   task automatic build_table();
      // Line fills on both buses, then hits on the rest of each line
      stim[0]  = make_row(BUS_I, OP_RD, 1'b0, 1'b0, 16'h0100, '0, '0, 32'h5a5a0040);
      stim[1]  = make_row(BUS_D, OP_RD, 1'b0, 1'b0, 16'h0200, '0, '0, 32'h5a5a0080);
      stim[2]  = make_row(BUS_I, OP_RD, 1'b0, 1'b0, 16'h0104, '0, '0, 32'h5a5a0041);
      stim[3]  = make_row(BUS_I, OP_RD, 1'b0, 1'b0, 16'h0108, '0, '0, 32'h5a5a0042);
      stim[4]  = make_row(BUS_I, OP_RD, 1'b0, 1'b0, 16'h010c, '0, '0, 32'h5a5a0043);
      stim[5]  = make_row(BUS_D, OP_RD, 1'b0, 1'b0, 16'h0204, '0, '0, 32'h5a5a0081);
      stim[6]  = make_row(BUS_D, OP_RD, 1'b0, 1'b0, 16'h0208, '0, '0, 32'h5a5a0082);
      stim[7]  = make_row(BUS_D, OP_RD, 1'b0, 1'b0, 16'h020c, '0, '0, 32'h5a5a0083);
      // Partial writes, one to a cached line and one that misses
      stim[8]  = make_row(BUS_D, OP_WR, 1'b0, 1'b0, 16'h0204, 32'hdeadbeef, 4'b0011, '0);
      stim[9]  = make_row(BUS_D, OP_RD, 1'b0, 1'b1, 16'h0204, '0, '0, '0);
      stim[10] = make_row(BUS_D, OP_WR, 1'b0, 1'b0, 16'h0314, 32'h12345678, 4'b1100, '0);
      stim[11] = make_row(BUS_D, OP_RD, 1'b0, 1'b1, 16'h0314, '0, '0, '0);
      // Same index, other tag, then back to the evicted line
      stim[12] = make_row(BUS_D, OP_RD, 1'b0, 1'b0, 16'h1200, '0, '0, 32'h5a5a0480);
      stim[13] = make_row(BUS_D, OP_RD, 1'b0, 1'b0, 16'h0200, '0, '0, 32'h5a5a0080);
      // Both buses in the same cycle
      stim[14] = make_row(BUS_I, OP_RD, 1'b1, 1'b0, 16'h0540, '0, '0, 32'h5a5a0150);
      stim[15] = make_row(BUS_D, OP_RD, 1'b0, 1'b0, 16'h0a80, '0, '0, 32'h5a5a02a0);
      stim[16] = make_row(BUS_I, OP_RD, 1'b1, 1'b0, 16'h0548, '0, '0, 32'h5a5a0152);
      stim[17] = make_row(BUS_D, OP_RD, 1'b0, 1'b0, 16'h0a8c, '0, '0, 32'h5a5a02a3);
      stim[18] = make_row(BUS_I, OP_RD, 1'b0, 1'b1, 16'h0204, '0, '0, '0);  // Sees the d write
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_counters();
      check_value("i_hit_cnt", 32'(i_hit_cnt), exp_hit[0]);
      check_value("i_miss_cnt", 32'(i_miss_cnt), exp_miss[0]);
      check_value("d_hit_cnt", 32'(d_hit_cnt), exp_hit[1]);
      check_value("d_miss_cnt", 32'(d_miss_cnt), exp_miss[1]);
   endtask

   // Tag model and memory model step, returns the data a read should see
   task automatic predict_op(input row_t row, output mem_bus_pkg::data_t exp);
      int                bus;
      cache_pkg::index_t idx;
      cache_pkg::tag_t   tag;
      logic [11:0]       w;
      bus = row.is_data ? 1 : 0;
      idx = row.addr[7:4];
      tag = row.addr[15:8];
      w   = row.addr[13:2];
      exp = '0;
      if (row.is_write) begin
         for (int b = 0; b < 4; b++) begin
            if (row.wstrb[b]) shadow[w][8*b +: 8] = row.wdata[8*b +: 8];
         end
      end else begin
         if (tag_valid[bus][idx] && tag_ref[bus][idx] == tag) begin
            exp_hit[bus]++;
         end else begin
            exp_miss[bus]++;   // Refill replaces the line
            tag_valid[bus][idx] = 1'b1;
            tag_ref[bus][idx]   = tag;
         end
         exp = row.calc ? shadow[w] : row.exp;
      end
   endtask

   // Called at a falling edge; drives one cycle later and waits for ready
   task automatic run_op(input row_t row, output mem_bus_pkg::data_t rdata);
      mem_bus_pkg::mem_req_t  req;
      mem_bus_pkg::mem_resp_t resp;
      req.valid = 1'b1;
      req.addr  = row.addr;
      req.wdata = row.wdata;
      req.wstrb = row.is_write ? row.wstrb : '0;
      @(negedge clk);
      if (row.is_data) d_req = req;
      else i_req = req;
      do begin
         @(negedge clk);
         resp = row.is_data ? d_resp : i_resp;
      end while (!resp.ready);
      rdata = resp.rdata;
      if (row.is_data) d_req = '0;
      else i_req = '0;
   endtask

   initial begin : watchdog
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: the table did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin : main
      row_t               a;
      row_t               b;
      mem_bus_pkg::data_t got_a;
      mem_bus_pkg::data_t got_b;
      mem_bus_pkg::data_t exp_a;
      mem_bus_pkg::data_t exp_b;
      int                 r;
      rst_n  = 1'b0;
      i_req  = '0;
      d_req  = '0;
      errors = 0;
      checks = 0;
      for (int i = 0; i < 4096; i++) shadow[i] = 32'(i) ^ 32'h5a5a0000;
      for (int c = 0; c < 2; c++) begin
         exp_hit[c]  = 0;
         exp_miss[c] = 0;
         for (int l = 0; l < `EXT_MEM_LINES; l++) begin
            tag_valid[c][l] = 1'b0;
            tag_ref[c][l]   = '0;
         end
      end
      build_table();

      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      check_value("i_resp.ready", 32'(i_resp.ready), 32'h0);
      check_value("d_resp.ready", 32'(d_resp.ready), 32'h0);
      check_value("mem_req.valid", 32'(mem_req.valid), 32'h0);
      check_counters();

      r = 0;
      while (r < NUM_ROWS) begin
         a = stim[r];
         predict_op(a, exp_a);
         if (a.pair) begin
            b = stim[r+1];
            predict_op(b, exp_b);
            fork
               run_op(a, got_a);
               run_op(b, got_b);
            join
            if (!b.is_write) begin
               check_value($sformatf("%s_resp.rdata row %0d", b.is_data ? "d" : "i", r + 1),
                           got_b, exp_b);
            end
         end else begin
            run_op(a, got_a);
         end
         if (!a.is_write) begin
            check_value($sformatf("%s_resp.rdata row %0d", a.is_data ? "d" : "i", r),
                        got_a, exp_a);
         end
         check_counters();
         r += a.pair ? 2 : 1;
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+hdl
hdl/mem_bus_pkg.sv
hdl/cache_pkg.sv
hdl/cache_store.sv
hdl/cache_ctrl.sv
hdl/bus_merge.sv
hdl/ext_mem.sv
test/tb_mem_model.sv
test/tb_ext_mem.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing
TOP       = tb_ext_mem
FILELIST  = verilog.f
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
